/* idctBlock.f */
+incdir+verilog
+incdir+sim
verilog/idctPkg.sv
verilog/idctBlockStore.sv
verilog/idctCosRom.sv
verilog/idctMac.sv
verilog/idctControl.sv
verilog/idctTop.sv
sim/idctTb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = -Wall -Wno-fatal --timing
TOP      = idctTb
RTL_TOP  = idctTop
FILELIST = idctBlock.f
OBJ_DIR  = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* sim/idctRefModel.svh */
`ifndef IDCT_REF_MODEL_SVH
`define IDCT_REF_MODEL_SVH

// model input and output blocks in row-major order
idctWordT modelIn [`IDCT_BLOCK_WORDS];
idctWordT modelOut [`IDCT_BLOCK_WORDS];

// Q15 value of c(k) cos((2n+1) k pi / 16) rounded to nearest
function automatic idctWordT cosQ15(input int n, input int k);
   real pi;
   real x;
   int  q;
   pi = 3.14159265358979;
   if (k == 0)
      x = 32768.0 / $sqrt(2.0);
   else
      x = 32768.0 * $cos(real'((2 * n + 1) * k) * pi / 16.0);
   if (x >= 0.0)
      q = $rtoi(x + 0.5);
   else
      q = $rtoi(x - 0.5);
   return idctWordT'(q);
endfunction

// row pass term keeps the low word of the product then shifts it arithmetically
function automatic idctWordT rowProduct(input idctWordT a, input idctWordT c);
   longint   p;
   idctWordT low;
   p   = longint'(a) * longint'(c);
   low = idctWordT'(p[`IDCT_WORD_BITS-1:0]);
   return low >>> `IDCT_ROW_SHIFT;
endfunction

// column pass term takes a bit field of the full product sign-extended
function automatic idctWordT colProduct(input idctWordT a, input idctWordT c);
   longint p;
   logic signed [`IDCT_COL_MSB-`IDCT_COL_LSB:0] field;
   p     = longint'(a) * longint'(c);
   field = p[`IDCT_COL_MSB:`IDCT_COL_LSB];
   return idctWordT'(field);
endfunction

task automatic modelBlock();
   idctWordT temp [`IDCT_BLOCK_WORDS];
   idctWordT acc;
   // temp[r][o] sums input row r against coefficient row o
   for (int r = 0; r < `IDCT_BLOCK_DIM; r++)
      for (int o = 0; o < `IDCT_BLOCK_DIM; o++)
      begin
         acc = '0;
         for (int t = 0; t < `IDCT_BLOCK_DIM; t++)
            acc = acc + rowProduct(modelIn[r*`IDCT_BLOCK_DIM+t], cosQ15(o, t));
         temp[r*`IDCT_BLOCK_DIM+o] = acc;
      end
   // out[r][o] sums temp column o against coefficient row r
   for (int r = 0; r < `IDCT_BLOCK_DIM; r++)
      for (int o = 0; o < `IDCT_BLOCK_DIM; o++)
      begin
         acc = '0;
         for (int t = 0; t < `IDCT_BLOCK_DIM; t++)
            acc = acc + colProduct(temp[t*`IDCT_BLOCK_DIM+o], cosQ15(r, t));
         modelOut[r*`IDCT_BLOCK_DIM+o] = acc;
      end
endtask

`endif

/* sim/idctTb.sv */
`timescale 1ns/1ps
`include "idct_settings.svh"

module idctTb import idctPkg::*; ();

   localparam int clkPeriod   = 40;
   localparam int blockCycles = 1300;
   localparam int smallBlocks = 3;
   localparam int fullBlocks  = 3;
   localparam int backBlocks  = 3;
   localparam int numBlocks   = smallBlocks + fullBlocks + 1 + backBlocks;
   localparam longint timeLimit = longint'(numBlocks) * blockCycles * clkPeriod;

   logic     clk;
   logic     reset;
   logic     start;
   idctWordT din;
   logic     reading;
   logic     done;
   idctWordT dout;

   integer   seed;
   int       blockNum;

   `include "idctRefModel.svh"

   idctTop idctTop_i (
      .clk     (clk),
      .reset   (reset),
      .start   (start),
      .din     (din),
      .reading (reading),
      .done    (done),
      .dout    (dout)
   );

   always #(clkPeriod / 2) clk = ~clk;

   initial
   begin
      #(timeLimit);
      $display("timeout: the run did not finish within %0d ns", timeLimit);
      $display("Done: errors found");
      $fatal(1, "watchdog expired");
   end

   task automatic checkWord(input idctWordT got, input idctWordT exp, input string what);
      if (got !== exp)
      begin
         $display("ERR %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
         $display("Done: errors found");
         $fatal(1, "stopped at the first mismatch");
      end
   endtask

   task automatic checkFlag(input logic got, input logic exp, input string what);
      if (got !== exp)
      begin
         $display("ERR %0t ns: %s is %b, expected %b", $time, what, got, exp);
         $display("Done: errors found");
         $fatal(1, "stopped at the first mismatch");
      end
   endtask

   // random words of the given signed width
   task automatic randomBlock(input int bits);
      idctWordT w;
      for (int i = 0; i < `IDCT_BLOCK_WORDS; i++)
      begin
         w = idctWordT'($random(seed));
         w = w <<< (`IDCT_WORD_BITS - bits);
         modelIn[i] = w >>> (`IDCT_WORD_BITS - bits);
      end
   endtask

   task automatic impulseBlock();
      idctWordT w;
      w = idctWordT'($random(seed));
      for (int i = 0; i < `IDCT_BLOCK_WORDS; i++)
         modelIn[i] = '0;
      modelIn[0] = w >>> 8;
   endtask

   task automatic sendBlock(input bit extraPulse);
      @(posedge clk);
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
      din   <= modelIn[0];
      @(negedge clk);
      checkFlag(reading, 1'b1, "reading during load");
      for (int k = 1; k < `IDCT_BLOCK_WORDS; k++)
      begin
         @(posedge clk);
         din   <= modelIn[k];
         // a start in the middle of the load must be ignored
         start <= extraPulse && (k == 20);
         @(negedge clk);
         checkFlag(reading, 1'b1, "reading during load");
      end
      @(posedge clk);
      din   <= '0;
      start <= 1'b0;
      @(negedge clk);
      checkFlag(reading, 1'b0, "reading after 64 words");
   endtask

   task automatic pulseStart();
      @(posedge clk);
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
   endtask

   task automatic waitForDone();
      int cycles;
      cycles = 0;
      while (done !== 1'b1)
      begin
         @(negedge clk);
         checkFlag(reading, 1'b0, "reading while busy");
         cycles++;
         if (cycles > blockCycles)
         begin
            $display("done did not rise within %0d cycles", blockCycles);
            $display("Done: errors found");
            $fatal(1, "done never came");
         end
      end
   endtask

   task automatic receiveBlock(input int num, input bit sameAll);
      idctWordT expected;
      for (int n = 0; n < `IDCT_BLOCK_WORDS; n++)
      begin
         @(negedge clk);
         expected = sameAll ? modelOut[0] : modelOut[n];
         checkFlag(done, 1'b1, "done during output");
         checkWord(dout, expected, $sformatf("block %0d word %0d", num, n));
      end
      @(negedge clk);
      checkFlag(done, 1'b0, "done after the last word");
   endtask

   task automatic runBlock(input int num, input bit extraPulse, input bit sameAll);
      modelBlock();
      sendBlock(extraPulse);
      if (extraPulse)
         pulseStart();
      waitForDone();
      receiveBlock(num, sameAll);
   endtask

   initial
   begin
      seed       = 32'hb62e_6d22;
      blockNum   = 0;
      clk        = 1'b0;
      reset      <= 1'b1;
      start      <= 1'b0;
      din        <= '0;
      repeat (4) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      checkFlag(reading, 1'b0, "reading after reset");
      checkFlag(done, 1'b0, "done after reset");
      checkWord(dout, '0, "dout after reset");

      // small signed inputs
      for (int i = 0; i < smallBlocks; i++)
      begin
         randomBlock(12);
         runBlock(blockNum, 1'b0, 1'b0);
         blockNum++;
      end

      // full range inputs hit the truncation in both passes
      for (int i = 0; i < fullBlocks; i++)
      begin
         randomBlock(`IDCT_WORD_BITS);
         runBlock(blockNum, 1'b0, 1'b0);
         blockNum++;
      end

      // only the DC word set so every output is equal
      impulseBlock();
      runBlock(blockNum, 1'b0, 1'b1);
      blockNum++;

      // back to back with stray start pulses while busy
      for (int i = 0; i < backBlocks; i++)
      begin
         randomBlock(16);
         runBlock(blockNum, 1'b1, 1'b0);
         blockNum++;
      end

      $display("Done: no errors");
      $finish;
   end

endmodule

/* verilog/idctTop.sv */
`timescale 1ns/1ps

module idctTop import idctPkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  logic     start,
   input  idctWordT din,
   output logic     reading,
   output logic     done,
   output idctWordT dout
);

   storeWriteT inWrite;
   storeWriteT tempWrite;
   storeWriteT outWrite;
   blockAddrT  inRdAddr;
   blockAddrT  tempRdAddr;
   blockAddrT  outRdAddr;
   blockIdxT   cosRow;
   blockIdxT   cosCol;
   macCmdT     macCmd;
   idctWordT   coef;
   idctWordT   result;
   idctWordT   inWord;
   idctWordT   tempWord;
   idctWordT   outWord;

   idctControl control (
      .clk        (clk),
      .reset      (reset),
      .start      (start),
      .din        (din),
      .reading    (reading),
      .done       (done),
      .dout       (dout),
      .inWrite    (inWrite),
      .inRdAddr   (inRdAddr),
      .tempRdAddr (tempRdAddr),
      .outRdAddr  (outRdAddr),
      .cosRow     (cosRow),
      .cosCol     (cosCol),
      .macCmd     (macCmd),
      .result     (result),
      .outWord    (outWord),
      .tempWrite  (tempWrite),
      .outWrite   (outWrite)
   );

   idctCosRom cosRom (
      .row  (cosRow),
      .col  (cosCol),
      .coef (coef)
   );

   idctMac mac (
      .clk      (clk),
      .reset    (reset),
      .cmd      (macCmd),
      .inWord   (inWord),
      .tempWord (tempWord),
      .coef     (coef),
      .result   (result)
   );

   // input block, row pass results, column pass results
   idctBlockStore inStore (
      .clk    (clk),
      .reset  (reset),
      .write  (inWrite),
      .rdAddr (inRdAddr),
      .rdData (inWord)
   );

   idctBlockStore tempStore (
      .clk    (clk),
      .reset  (reset),
      .write  (tempWrite),
      .rdAddr (tempRdAddr),
      .rdData (tempWord)
   );

   idctBlockStore outStore (
      .clk    (clk),
      .reset  (reset),
      .write  (outWrite),
      .rdAddr (outRdAddr),
      .rdData (outWord)
   );

endmodule

/* verilog/idctControl.sv */
`timescale 1ns/1ps
`include "idct_settings.svh"

module idctControl import idctPkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  logic       start,
   input  idctWordT   din,
   output logic       reading,
   output logic       done,
   output idctWordT   dout,
   output storeWriteT inWrite,
   output blockAddrT  inRdAddr,
   output blockAddrT  tempRdAddr,
   output blockAddrT  outRdAddr,
   output blockIdxT   cosRow,
   output blockIdxT   cosCol,
   output macCmdT     macCmd,
   input  idctWordT   result,
   input  idctWordT   outWord,
   output storeWriteT tempWrite,
   output storeWriteT outWrite
);

   typedef enum logic [2:0] {idle, load, rowRun, rowFlush, colRun, colFlush, unload} phaseT;

   phaseT     phase;
   stepCountU step;
   stepCountU stepD1;
   stepCountU stepD2;
   stepCountU stepD3;
   logic      running;
   logic      lastWord;
   logic      wrapped;
   logic      sumReady;
   blockAddrT stepAddr;
   blockAddrT sumAddr;

   assign running  = (phase == rowRun) || (phase == colRun);
   assign lastWord = step.flat == stepFlatT'(`IDCT_BLOCK_WORDS - 1);
   assign wrapped  = step.flat == '0;

   // load and unload walk the block in row-major order
   assign stepAddr = '{row: step.idx.rowIdx, col: step.idx.termIdx};

   // finished sums land at [row][out] of the step three cycles back
   assign sumAddr = '{row: stepD3.idx.rowIdx, col: stepD3.idx.outIdx};

   assign reading = phase == load;

   assign inWrite = '{en: phase == load, addr: stepAddr, data: din};
   assign outRdAddr = stepAddr;

   // outside the passes everything points at step 0 to prime the operands
   always_comb
   begin
      inRdAddr   = '0;
      tempRdAddr = '0;
      cosRow     = '0;
      cosCol     = '0;
      if (phase == rowRun)
      begin
         inRdAddr = '{row: step.idx.rowIdx, col: step.idx.termIdx};
         cosRow   = step.idx.outIdx;
         cosCol   = step.idx.termIdx;
      end
      else if (phase == colRun)
      begin
         tempRdAddr = '{row: step.idx.termIdx, col: step.idx.outIdx};
         cosRow     = step.idx.rowIdx;
         cosCol     = step.idx.termIdx;
      end
   end

   assign macCmd.pass    = (phase inside {rowFlush, colRun, colFlush}) ? colPass : rowPass;
   assign macCmd.clear   = ((phase == load) && lastWord) || (phase == rowFlush);
   assign macCmd.restart = running && (stepD3.idx.termIdx == '1);
   assign macCmd.flush   = (phase == rowFlush) || (phase == colFlush);

   assign sumReady = macCmd.restart || macCmd.flush;

   assign tempWrite = '{
      en: sumReady && ((phase == rowRun) || (phase == rowFlush)),
      addr: sumAddr,
      data: result
   };
   assign outWrite = '{
      en: sumReady && ((phase == colRun) || (phase == colFlush)),
      addr: sumAddr,
      data: result
   };

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         phase  <= idle;
         step   <= '0;
         stepD1 <= '0;
         stepD2 <= '0;
         stepD3 <= '0;
         done   <= 1'b0;
         dout   <= '0;
      end
      else
      begin
         // delay line matches the three register stages of the accumulator
         if (running)
         begin
            stepD1 <= step;
            stepD2 <= stepD1;
            stepD3 <= stepD2;
         end
         else
         begin
            stepD1 <= '0;
            stepD2 <= '0;
            stepD3 <= '0;
         end

         case (phase)
            idle:
            begin
               done <= 1'b0;
               step <= '0;
               if (start)
                  phase <= load;
            end
            load:
            begin
               if (lastWord)
               begin
                  step.flat <= stepFlatT'(1);
                  phase     <= rowRun;
               end
               else
                  step.flat <= step.flat + stepFlatT'(1);
            end
            rowRun:
            begin
               step.flat <= step.flat + stepFlatT'(1);
               if (wrapped)
                  phase <= rowFlush;
            end
            rowFlush:
            begin
               step.flat <= stepFlatT'(1);
               phase     <= colRun;
            end
            colRun:
            begin
               step.flat <= step.flat + stepFlatT'(1);
               if (wrapped)
                  phase <= colFlush;
            end
            colFlush:
            begin
               step  <= '0;
               done  <= 1'b1;
               phase <= unload;
            end
            unload:
            begin
               dout <= outWord;
               if (lastWord)
               begin
                  step  <= '0;
                  phase <= idle;
               end
               else
                  step.flat <= step.flat + stepFlatT'(1);
            end
            default:
               phase <= idle;
         endcase
      end
   end

endmodule

/* verilog/idctMac.sv */
`timescale 1ns/1ps
`include "idct_settings.svh"

module idctMac import idctPkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  macCmdT   cmd,
   input  idctWordT inWord,
   input  idctWordT tempWord,
   input  idctWordT coef,
   output idctWordT result
);

   localparam int colBits = `IDCT_COL_MSB - `IDCT_COL_LSB + 1;

   idctWordT opA;
   idctWordT opB;
   idctWordT operand;
   idctWordT prod;
   idctWordT sum;
   idctWordT lowWord;
   idctWordT scaled;
   logic signed [2*`IDCT_WORD_BITS-1:0] fullProd;

   assign operand = (cmd.pass == colPass) ? tempWord : inWord;

   assign fullProd = opA * opB;
   assign lowWord  = fullProd[`IDCT_WORD_BITS-1:0];

   // row pass truncates to a word then shifts, column pass picks a bit field
   always_comb
   begin
      if (cmd.pass == rowPass)
         scaled = lowWord >>> `IDCT_ROW_SHIFT;
      else
         scaled = {{(`IDCT_WORD_BITS - colBits){fullProd[`IDCT_COL_MSB]}},
                   fullProd[`IDCT_COL_MSB:`IDCT_COL_LSB]};
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         opA  <= '0;
         opB  <= '0;
         prod <= '0;
         sum  <= '0;
      end
      else
      begin
         // operands still load here so step 0 is ready after a clear
         opA <= operand;
         opB <= coef;
         if (cmd.clear)
         begin
            prod <= '0;
            sum  <= '0;
         end
         else
         begin
            prod <= scaled;
            if (cmd.restart)
               sum <= prod;
            else
               sum <= sum + prod;
         end
      end
   end

   // on flush the last product has not been added yet
   assign result = cmd.flush ? sum + prod : sum;

endmodule

/* verilog/idctCosRom.sv */
`timescale 1ns/1ps
`include "idct_settings.svh"

module idctCosRom import idctPkg::*; (
   input  blockIdxT row,
   input  blockIdxT col,
   output idctWordT coef
);

   // Q15 cosine table with negative entries kept as 16-bit two's complement
   localparam coefT cosTable [`IDCT_BLOCK_DIM][`IDCT_BLOCK_DIM] = '{
      '{16'd23170, 16'd32138, 16'd30274, 16'd27246,
        16'd23170, 16'd18205, 16'd12540, 16'd6393},
      '{16'd23170, 16'd27246, 16'd12540, 16'd59143,
        16'd42366, 16'd33398, 16'd35262, 16'd47331},
      '{16'd23170, 16'd18205, 16'd52996, 16'd33398,
        16'd42366, 16'd6393, 16'd30274, 16'd27246},
      '{16'd23170, 16'd6393, 16'd35262, 16'd47331,
        16'd23170, 16'd27246, 16'd52996, 16'd33398},
      '{16'd23170, 16'd59143, 16'd35262, 16'd18205,
        16'd23170, 16'd38290, 16'd52996, 16'd32138},
      '{16'd23170, 16'd47331, 16'd52996, 16'd32138,
        16'd42366, 16'd59143, 16'd30274, 16'd38290},
      '{16'd23170, 16'd38290, 16'd12540, 16'd6393,
        16'd42366, 16'd32138, 16'd35262, 16'd18205},
      '{16'd23170, 16'd33398, 16'd30274, 16'd38290,
        16'd23170, 16'd47331, 16'd12540, 16'd59143}
   };

   // sign extended up to a full data word
   assign coef = idctWordT'(cosTable[row][col]);

endmodule

/* verilog/idctBlockStore.sv */
`timescale 1ns/1ps
`include "idct_settings.svh"

module idctBlockStore import idctPkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  storeWriteT write,
   input  blockAddrT  rdAddr,
   output idctWordT   rdData
);

   // row-major block so the {row, col} address is the flat word index
   idctWordT mem [`IDCT_BLOCK_WORDS];

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         for (int i = 0; i < `IDCT_BLOCK_WORDS; i++)
            mem[i] <= '0;
      end
      else if (write.en)
      begin
         mem[write.addr] <= write.data;
      end
   end

   assign rdData = mem[rdAddr];

endmodule

/* verilog/idctPkg.sv */
`include "idct_settings.svh"

package idctPkg;

   typedef logic signed [`IDCT_WORD_BITS-1:0] idctWordT;
   typedef logic signed [`IDCT_COEF_BITS-1:0] coefT;

   typedef logic [$clog2(`IDCT_BLOCK_DIM)-1:0] blockIdxT;
   typedef logic [3*$clog2(`IDCT_BLOCK_DIM)-1:0] stepFlatT;

   typedef struct packed {
      blockIdxT row;
      blockIdxT col;
   } blockAddrT;

   // one step of a pass with the output index on top and the term index at the bottom
   typedef struct packed {
      blockIdxT outIdx;
      blockIdxT rowIdx;
      blockIdxT termIdx;
   } stepFieldsT;

   typedef union packed {
      stepFlatT   flat;
      stepFieldsT idx;
   } stepCountU;

   typedef enum logic {rowPass, colPass} passT;

   typedef struct packed {
      passT pass;
      logic clear;
      logic restart;
      logic flush;
   } macCmdT;

   typedef struct packed {
      logic      en;
      blockAddrT addr;
      idctWordT  data;
   } storeWriteT;

endpackage

/* verilog/idct_settings.svh */
`ifndef IDCT_SETTINGS_SVH
`define IDCT_SETTINGS_SVH

// data and coefficient widths
`define IDCT_WORD_BITS 32
`define IDCT_COEF_BITS 16

// block geometry
`define IDCT_BLOCK_DIM 8
`define IDCT_BLOCK_WORDS 64

// row pass keeps the low word of the product and shifts it down
`define IDCT_ROW_SHIFT 3

// column pass keeps this bit range of the full product
`define IDCT_COL_LSB 19
`define IDCT_COL_MSB 47

`endif
